/* compile.f */
source/memmap_pkg.sv
source/mem_port_if.sv
source/memmap_demux.sv
source/mem_bank.sv
source/memmap_subsys.sv
sim/tb_memmap_subsys.sv

/* sim/tb_memmap_subsys.sv */
module tb_memmap_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  import memmap_pkg::*;

  localparam int unsigned NB_REGION  = 2;
  localparam int unsigned BANK_WORDS = 256;
  // about 300 cycles of traffic, so this leaves a wide margin
  localparam int unsigned MAX_CYCLES = 2000;

  logic                    clk;
  logic                    rst_n;
  logic                    clear;
  addr_t [NB_REGION-1:0]   region_start;
  addr_t [NB_REGION-1:0]   region_end;
  logic                    req;
  addr_t                   add;
  logic                    wen;
  data_t                   wdata;
  be_t                     be;
  logic                    gnt;
  logic                    r_valid;
  data_t                   r_data;
  logic                    r_opc;

  // reference copy of the bank contents
  data_t model_mem [NB_REGION][BANK_WORDS];
  bit    written   [NB_REGION][BANK_WORDS];

  logic [31:0] lcg_state;
  int          errors;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;

  memmap_subsys #(
    .NB_REGION  ( NB_REGION  ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_memmap_subsys (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .region_start_i ( region_start ),
    .region_end_i   ( region_end   ),
    .req_i          ( req          ),
    .add_i          ( add          ),
    .wen_i          ( wen          ),
    .data_i         ( wdata        ),
    .be_i           ( be           ),
    .gnt_o          ( gnt          ),
    .r_valid_o      ( r_valid      ),
    .r_data_o       ( r_data       ),
    .r_opc_o        ( r_opc        )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no end of tests after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic data_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  // highest matching region wins, region 0 when nothing matches
  function automatic int find_region(addr_t a);
    int r;
    r = 0;
    for (int i = 0; i < NB_REGION; i++) begin
      if ((a >= region_start[i]) && (a < region_end[i])) begin
        r = i;
      end
    end
    return r;
  endfunction

  function automatic int local_offset(addr_t a, int r);
    return int'((a - region_start[r]) & 32'h0000_ffff);
  endfunction

  // one request, wait for grant, take the response in the next cycle
  task automatic do_access(input addr_t a_addr, input logic a_rd, input data_t a_data,
                           input be_t a_be, output data_t rsp_data, output logic rsp_opc);
    @(negedge clk);
    req   = 1'b1;
    add   = a_addr;
    wen   = a_rd;
    wdata = a_data;
    be    = a_be;
    do begin
      @(posedge clk);
    end while (!gnt);
    @(negedge clk);
    check_eq(r_valid, 1'b1, "r_valid one cycle after grant");
    rsp_data = r_data;
    rsp_opc  = r_opc;
    req      = 1'b0;
  endtask

  task automatic write_word(input addr_t a, input data_t d, input be_t b);
    int    r;
    int    w;
    data_t rsp;
    logic  opc;
    r = find_region(a);
    w = local_offset(a, r) / 4;
    do_access(a, 1'b0, d, b, rsp, opc);
    check_eq(opc, (w >= BANK_WORDS), $sformatf("write opcode at %h", a));
    if (w < BANK_WORDS) begin
      for (int i = 0; i < MM_BW; i++) begin
        if (b[i]) begin
          model_mem[r][w][8*i +: 8] = d[8*i +: 8];
        end
      end
      written[r][w] = 1'b1;
    end
  endtask

  task automatic read_check(input addr_t a);
    int    r;
    int    w;
    data_t rsp;
    logic  opc;
    r = find_region(a);
    w = local_offset(a, r) / 4;
    do_access(a, 1'b1, '0, '0, rsp, opc);
    if (w < BANK_WORDS) begin
      check_eq(rsp, model_mem[r][w], $sformatf("read data at %h", a));
      check_eq(opc, 1'b0, $sformatf("read opcode at %h", a));
    end else begin
      check_eq(rsp, '0, $sformatf("out of range data at %h", a));
      check_eq(opc, 1'b1, $sformatf("out of range opcode at %h", a));
    end
  endtask

  // reads back every word written so far through the default map
  task automatic verify_written();
    for (int r = 0; r < NB_REGION; r++) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        if (written[r][w]) begin
          read_check(region_start[r] + addr_t'(4 * w));
        end
      end
    end
  endtask

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_errors);
    end
  endtask

  task automatic test_routing();
    int offs [5];
    offs = '{32'h0, 32'h4, 32'h10, 32'h200, 32'h3fc};
    start_test();
    foreach (offs[i]) begin
      write_word(32'h1000 + offs[i], next_rand(), 4'hf);
      write_word(32'h2000 + offs[i], next_rand(), 4'hf);
    end
    foreach (offs[i]) begin
      read_check(32'h1000 + offs[i]);
      read_check(32'h2000 + offs[i]);
    end
    // same offset in region 1 must not touch region 0
    write_word(32'h2010, next_rand(), 4'hf);
    read_check(32'h1010);
    read_check(32'h2010);
    finish_test("routing");
  endtask

  task automatic test_byte_enables();
    be_t pats [5];
    pats = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
    start_test();
    foreach (pats[i]) begin
      write_word(32'h1004, next_rand(), pats[i]);
      read_check(32'h1004);
      write_word(32'h2200, next_rand(), pats[i]);
      read_check(32'h2200);
    end
    finish_test("byte_enables");
  endtask

  task automatic test_pipeline();
    data_t exp_q [$];
    addr_t a;
    int    r;
    int    n;
    start_test();
    n = 8;
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_eq(r_valid, 1'b1, "pipelined r_valid");
        check_eq(r_data, exp_q.pop_front(), "pipelined read data");
      end
      if (i < n) begin
        a = ((i % 2) == 0) ? 32'h1000 : 32'h2000;
        a = a + addr_t'(4 * ((i / 2) % 2));
        r = find_region(a);
        exp_q.push_back(model_mem[r][local_offset(a, r) / 4]);
        req = 1'b1;
        add = a;
        wen = 1'b1;
        @(posedge clk);
        check_eq(gnt, 1'b1, "gnt in pipelined request cycle");
      end else begin
        req = 1'b0;
      end
    end
    finish_test("pipeline");
  endtask

  task automatic test_bank_error();
    start_test();
    @(negedge clk);
    region_end[1] = 32'h3000;
    read_check(32'h2400);
    write_word(32'h2400, next_rand(), 4'hf);
    write_word(32'h27fc, next_rand(), 4'hf);
    read_check(32'h2400);
    verify_written();
    @(negedge clk);
    region_end[1] = 32'h2400;
    finish_test("bank_error");
  endtask

  task automatic test_default_overlap();
    start_test();
    // no region matches, falls back to region 0 at offset 0x20
    write_word(32'h0001_1020, next_rand(), 4'hf);
    read_check(32'h1020);
    read_check(32'h0001_1020);
    @(negedge clk);
    region_start[1] = 32'h1200;
    write_word(32'h1300, next_rand(), 4'hf);
    read_check(32'h1300);
    read_check(32'h1100);
    @(negedge clk);
    region_start[1] = 32'h2000;
    read_check(32'h2100);
    verify_written();
    finish_test("default_overlap");
  endtask

  task automatic test_clear();
    start_test();
    @(negedge clk);
    req = 1'b1;
    add = 32'h1000;
    wen = 1'b1;
    do begin
      @(posedge clk);
    end while (!gnt);
    @(negedge clk);
    check_eq(r_valid, 1'b1, "r_valid before clear");
    // a second request in the response cycle, its response dropped by clear
    clear = 1'b1;
    @(negedge clk);
    check_eq(r_valid, 1'b0, "r_valid after clear");
    req   = 1'b0;
    clear = 1'b0;
    verify_written();
    finish_test("clear");
  endtask

  initial begin
    clk_setup: begin
      rst_n        = 1'b0;
      clear        = 1'b0;
      req          = 1'b0;
      add          = '0;
      wen          = 1'b1;
      wdata        = '0;
      be           = '0;
      region_start = {32'h2000, 32'h1000};
      region_end   = {32'h2400, 32'h1400};
    end
    lcg_state    = 32'd91;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_routing();
    test_byte_enables();
    test_pipeline();
    test_bank_error();
    test_default_overlap();
    test_clear();

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if ((tests_failed == 0) && (errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* source/memmap_subsys.sv */
module memmap_subsys #(
  parameter int unsigned NB_REGION  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,

  // region map, start inclusive and end exclusive
  input  memmap_pkg::addr_t [NB_REGION-1:0]  region_start_i,
  input  memmap_pkg::addr_t [NB_REGION-1:0]  region_end_i,

  // core data port, request side
  input  logic                               req_i,
  input  memmap_pkg::addr_t                  add_i,
  input  logic                               wen_i,
  input  memmap_pkg::data_t                  data_i,
  input  memmap_pkg::be_t                    be_i,

  // core data port, response side
  output logic                               gnt_o,
  output logic                               r_valid_o,
  output memmap_pkg::data_t                  r_data_o,
  output logic                               r_opc_o
);

  // core side of the demux
  mem_port_if core_port ();

  // one port per bank
  mem_port_if region_port [NB_REGION-1:0] ();

  assign core_port.req  = req_i;
  assign core_port.add  = add_i;
  assign core_port.wen  = wen_i;
  assign core_port.data = data_i;
  assign core_port.be   = be_i;

  assign gnt_o     = core_port.gnt;
  assign r_valid_o = core_port.r_valid;
  assign r_data_o  = core_port.r_data;
  assign r_opc_o   = core_port.r_opc;

  memmap_demux #(
    .NB_REGION ( NB_REGION )
  ) i_memmap_demux (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .region_start_i ( region_start_i ),
    .region_end_i   ( region_end_i   ),
    .core           ( core_port      ),
    .region         ( region_port    )
  );

  for (genvar gi = 0; gi < NB_REGION; gi++) begin : gen_bank
    mem_bank #(
      .BANK_WORDS ( BANK_WORDS )
    ) i_mem_bank (
      .clk_i   ( clk_i           ),
      .rst_ni  ( rst_ni          ),
      .clear_i ( clear_i         ),
      .port    ( region_port[gi] )
    );
  end

endmodule

/* source/mem_bank.sv */
module mem_bank #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,

  mem_port_if.target port
);
  import memmap_pkg::*;

  localparam int unsigned IW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  data_t              mem_q [BANK_WORDS];

  logic [MM_AW-3:0]   word_idx;
  logic [IW-1:0]      mem_idx;
  logic               in_range;
  logic               access;
  logic               wr_en;

  logic               r_valid_q;
  data_t              r_data_q;
  logic               r_opc_q;

  // the bank never stalls
  assign port.gnt = port.req;

  // word index from the local byte address
  assign word_idx = port.add[MM_AW-1:2];
  assign mem_idx  = word_idx[IW-1:0];
  assign in_range = (word_idx < BANK_WORDS);

  assign access = port.req & port.gnt;
  assign wr_en  = access & ~port.wen & in_range;

  // byte-lane write
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < MM_BW; b++) begin
        if (port.be[b]) begin
          mem_q[mem_idx][8*b +: 8] <= port.data[8*b +: 8];
        end
      end
    end
  end

  // one response per granted access, one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= access;
    end
  end

  // response payload, zero data outside the bank
  always_ff @(posedge clk_i) begin
    if (access) begin
      r_opc_q <= ~in_range;
      if (in_range && port.wen) begin
        r_data_q <= mem_q[mem_idx];
      end else begin
        r_data_q <= '0;
      end
    end
  end

  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;
  assign port.r_opc   = r_opc_q;

endmodule

/* source/memmap_demux.sv */
module memmap_demux #(
  parameter int unsigned NB_REGION = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,

  input  memmap_pkg::addr_t [NB_REGION-1:0]   region_start_i,
  input  memmap_pkg::addr_t [NB_REGION-1:0]   region_end_i,

  mem_port_if.target                          core,
  mem_port_if.requester                       region [NB_REGION-1:0]
);
  import memmap_pkg::*;

  // at least one bit so a single region still has an index
  localparam int unsigned RW = (NB_REGION > 1) ? $clog2(NB_REGION) : 1;

  typedef logic [RW-1:0] region_idx_t;

  typedef enum logic {
    idle,
    respond
  } state_e;

  state_e      state_q;
  state_e      state_d;

  region_idx_t region_d;
  region_idx_t region_q;

  logic        grant;

  // per-region views of the interface array
  logic  [NB_REGION-1:0] region_req;
  logic  [NB_REGION-1:0] region_gnt;
  logic  [NB_REGION-1:0] region_r_valid;
  data_t [NB_REGION-1:0] region_r_data;
  logic  [NB_REGION-1:0] region_r_opc;

  // address decode, later regions override earlier ones
  always_comb begin
    region_d = '0;
    for (int unsigned i = 0; i < NB_REGION; i++) begin
      if ((core.add >= region_start_i[i]) && (core.add < region_end_i[i])) begin
        region_d = region_idx_t'(i);
      end
    end
  end

  // steer req to the selected region only
  always_comb begin
    region_req           = '0;
    region_req[region_d] = core.req;
  end

  assign core.gnt = region_gnt[region_d];
  assign grant    = core.req & core.gnt;

  // every grant is followed by exactly one response cycle
  always_comb begin
    state_d = idle;
    if (grant) begin
      state_d = respond;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else if (clear_i) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // remember where the response will come from
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      region_q <= '0;
    end else if (clear_i) begin
      region_q <= '0;
    end else if (grant) begin
      region_q <= region_d;
    end
  end

  // response path back to the core
  always_comb begin
    case (state_q)
      respond: begin
        core.r_valid = region_r_valid[region_q];
        core.r_data  = region_r_data[region_q];
        core.r_opc   = region_r_opc[region_q];
      end
      default: begin
        core.r_valid = 1'b0;
        core.r_data  = '0;
        core.r_opc   = 1'b0;
      end
    endcase
  end

  for (genvar gi = 0; gi < NB_REGION; gi++) begin : gen_region
    // rebase to the region start, keep only the local bits
    assign region[gi].add[MM_AW-1:MM_AWC] = '0;
    assign region[gi].add[MM_AWC-1:0]     = core.add[MM_AWC-1:0]
                                            - region_start_i[gi][MM_AWC-1:0];

    assign region[gi].req  = region_req[gi];
    assign region[gi].wen  = core.wen;
    assign region[gi].data = core.data;
    assign region[gi].be   = core.be;

    assign region_gnt[gi]     = region[gi].gnt;
    assign region_r_valid[gi] = region[gi].r_valid;
    assign region_r_data[gi]  = region[gi].r_data;
    assign region_r_opc[gi]   = region[gi].r_opc;
  end

endmodule

/* source/mem_port_if.sv */
interface mem_port_if;
  import memmap_pkg::*;

  // request side, driven by the requester
  logic  req;
  addr_t add;
  // high means read
  logic  wen;
  data_t data;
  be_t   be;

  // response side, driven by the target
  logic  gnt;
  logic  r_valid;
  data_t r_data;
  // high flags an error
  logic  r_opc;

  modport requester (
    output req,
    output add,
    output wen,
    output data,
    output be,
    input  gnt,
    input  r_valid,
    input  r_data,
    input  r_opc
  );

  modport target (
    input  req,
    input  add,
    input  wen,
    input  data,
    input  be,
    output gnt,
    output r_valid,
    output r_data,
    output r_opc
  );

endinterface

/* source/memmap_pkg.sv */
package memmap_pkg;

  // full byte address width on the core side
  localparam int unsigned MM_AW = 32;

  // useful part of a rebased address inside one region
  localparam int unsigned MM_AWC = 16;

  // data word width
  localparam int unsigned MM_DW = 32;

  // one enable per byte lane
  localparam int unsigned MM_BW = MM_DW / 8;

  // byte address, core side or local after rebasing
  typedef logic [MM_AW-1:0] addr_t;

  // one data word
  typedef logic [MM_DW-1:0] data_t;

  // byte enables for one data word
  typedef logic [MM_BW-1:0] be_t;

endpackage
